// File: Makefile
TOP := tb_l2_tlb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
rtl/l2tlb_pkg.sv
rtl/va_bank.sv
rtl/hit_select.sv
rtl/pa_table.sv
rtl/lookup_ctrl.sv
rtl/l2_tlb.sv
sim/tb_l2_tlb.sv

// File: rtl/hit_select.sv
`timescale 1ns/1ps
`default_nettype none

module hit_select import l2tlb_pkg::*; (
   input  logic [N_BANKS-1:0][1:0] hit_i,
   input  logic [N_BANKS-1:0][1:0] prot_i,
   input  logic [N_BANKS-1:0][1:0] coh_i,
   input  logic [SRCH_ADDR_W-1:0]  raddr_q_i,
   output logic                    hit_o,
   output logic                    prot_o,
   output logic                    multi_o,
   output logic                    coh_o,
   output logic [PA_ADDR_W-1:0]    pa_idx_o
);

   logic [BANK_W-1:0] win_bank;
   logic              win_port;
   logic [BANK_W+1:0] n_hits;              // Up to 2 * N_BANKS ways

   // Walk downwards so the lowest bank and port 0 win last
   always_comb begin
      hit_o    = 1'b0;
      coh_o    = 1'b0;
      win_bank = '0;
      win_port = 1'b0;
      n_hits   = '0;
      for (int b = N_BANKS - 1; b >= 0; b--) begin
         for (int p = 1; p >= 0; p--) begin
            if (hit_i[b][p]) begin
               hit_o    = 1'b1;
               coh_o    = coh_i[b][p];
               win_bank = BANK_W'(b);
               win_port = 1'(p);
            end
            n_hits = n_hits + (BANK_W+2)'(hit_i[b][p]);
         end
      end
   end

   assign prot_o  = |prot_i;
   assign multi_o = n_hits > (BANK_W+2)'(1);  // Only within this search step

   // Entry times N_BANKS plus bank
   assign pa_idx_o = {raddr_q_i[SRCH_ADDR_W-1:OFFSET_W], win_port,
                      raddr_q_i[OFFSET_W-1:0], win_bank};

endmodule

`default_nettype wire

// File: rtl/l2_tlb.sv
`timescale 1ns/1ps
`default_nettype none

module l2_tlb import l2tlb_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic                  we_i,
   input  logic [CFG_ADDR_W-1:0] waddr_i,
   input  logic [CFG_DATA_W-1:0] wdata_i,
   input  logic                  start_i,
   output logic                  busy_o,
   input  logic [S_ADDR_W-1:0]   in_addr_i,
   input  logic                  rw_type_i,
   input  logic                  out_ready_i,
   output logic                  out_valid_o,
   output logic                  hit_o,
   output logic                  miss_o,
   output logic                  prot_o,
   output logic                  multi_o,
   output logic                  coherent_o,
   output logic [M_ADDR_W-1:0]   out_addr_o
);

   logic                    cfg_pa_sel;
   logic [BANK_W-1:0]       cfg_bank;
   logic [VA_ADDR_W-1:0]    cfg_entry;
   logic [N_BANKS-1:0]      bank_we, bank_valid;
   logic [N_BANKS-1:0][1:0] bank_hit, bank_prot, bank_coh;
   logic                    pa_we, pa_re, search_en;
   logic [SRCH_ADDR_W-1:0]  search_addr, search_addr_q;
   logic                    sel_hit, sel_prot, sel_multi, sel_coh;
   logic [PA_ADDR_W-1:0]    pa_idx, pa_raddr;
   logic [PPN_W-1:0]        ppn;

   // Config word address is {pa_sel, entry, bank}
   assign cfg_bank   = waddr_i[BANK_W-1:0];
   assign cfg_entry  = waddr_i[BANK_W+VA_ADDR_W-1:BANK_W];
   assign cfg_pa_sel = waddr_i[BANK_W+VA_ADDR_W];
   assign pa_we      = we_i && cfg_pa_sel;

   // Address of the step whose compare comes back next cycle
   always_ff @(posedge clk_i) begin
      if (search_en) search_addr_q <= search_addr;
   end

   for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
      assign bank_we[b] = we_i && !cfg_pa_sel && (cfg_bank == BANK_W'(b));

      va_bank u_va_bank (
         .clk_i     (clk_i),
         .we_i      (bank_we[b]),
         .waddr_i   (cfg_entry),
         .wdata_i   (wdata_i[VA_DATA_W-1:0]),
         .re_i      (search_en),
         .raddr_i   (search_addr),
         .vpn_i     (in_addr_i[S_ADDR_W-1:PAGE_W]),
         .rw_type_i (rw_type_i),
         .valid_o   (bank_valid[b]),
         .hit_o     (bank_hit[b]),
         .prot_o    (bank_prot[b]),
         .coh_o     (bank_coh[b])
      );
   end

   hit_select u_hit_select (
      .hit_i     (bank_hit),
      .prot_i    (bank_prot),
      .coh_i     (bank_coh),
      .raddr_q_i (search_addr_q),
      .hit_o     (sel_hit),
      .prot_o    (sel_prot),
      .multi_o   (sel_multi),
      .coh_o     (sel_coh),
      .pa_idx_o  (pa_idx)
   );

   pa_table u_pa_table (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .we_i    (pa_we),
      .waddr_i (waddr_i[PA_ADDR_W-1:0]),
      .wdata_i (wdata_i[PPN_W-1:0]),
      .re_i    (pa_re),
      .raddr_i (pa_raddr),
      .ppn_o   (ppn)
   );

   lookup_ctrl u_lookup_ctrl (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .start_i       (start_i),
      .rw_type_i     (rw_type_i),
      .busy_o        (busy_o),
      .bank_we_i     (|bank_we),
      .pa_we_i       (pa_we),
      .search_en_o   (search_en),
      .search_addr_o (search_addr),
      .set_i         (in_addr_i[PAGE_W+SET_W-1:PAGE_W]),
      .res_valid_i   (&bank_valid),
      .hit_i         (sel_hit),
      .prot_i        (sel_prot),
      .multi_i       (sel_multi),
      .coh_i         (sel_coh),
      .pa_idx_i      (pa_idx),
      .pa_re_o       (pa_re),
      .pa_raddr_o    (pa_raddr),
      .out_ready_i   (out_ready_i),
      .out_valid_o   (out_valid_o),
      .hit_o         (hit_o),
      .miss_o        (miss_o),
      .prot_o        (prot_o),
      .multi_o       (multi_o),
      .coh_o         (coherent_o)
   );

   assign out_addr_o = {ppn, in_addr_i[PAGE_W-1:0]};   // PPN plus page offset

endmodule

`default_nettype wire

// File: rtl/l2tlb_pkg.sv
`default_nettype none

package l2tlb_pkg;

   // Address widths
   localparam int S_ADDR_W = 32;             // Virtual address on the slave side
   localparam int M_ADDR_W = 40;             // Physical address on the master side
   localparam int PAGE_W   = 12;             // 4 KiB pages
   localparam int VPN_W    = S_ADDR_W - PAGE_W;
   localparam int PPN_W    = M_ADDR_W - PAGE_W;

   // TLB geometry
   localparam int N_SETS    = 32;
   localparam int SET_W     = 5;
   localparam int N_OFFSETS = 4;             // Steps per set and port
   localparam int OFFSET_W  = 2;
   localparam int N_BANKS   = 4;
   localparam int BANK_W    = 2;

   // Set and offset of one search step, shared by both ports
   localparam int SRCH_ADDR_W = SET_W + OFFSET_W;

   // Entry address inside a bank is {set, port, offset}
   localparam int VA_ADDR_W = SET_W + 1 + OFFSET_W;
   localparam int VA_DEPTH  = N_SETS * 2 * N_OFFSETS;
   localparam int VA_DATA_W = VPN_W + 4;

   // PA table index is {entry, bank}
   localparam int PA_ADDR_W = VA_ADDR_W + BANK_W;
   localparam int PA_DEPTH  = VA_DEPTH * N_BANKS;

   // Configuration port
   localparam int CFG_ADDR_W = 32;
   localparam int CFG_DATA_W = 64;

   // Flag bits of a VA entry, above the VPN
   localparam int FLAG_VALID = VPN_W;
   localparam int FLAG_RD    = VPN_W + 1;
   localparam int FLAG_WR    = VPN_W + 2;
   localparam int FLAG_COH   = VPN_W + 3;

   typedef enum logic [1:0] {
      S_IDLE,
      S_SEARCH,
      S_DONE
   } search_state_t;

   typedef enum logic [1:0] {
      O_IDLE,
      O_WAIT_WRITE,
      O_SEND
   } out_state_t;

endpackage

`default_nettype wire

// File: rtl/lookup_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_ctrl import l2tlb_pkg::*; (
   input  logic                   clk_i,
   input  logic                   rst_ni,
   input  logic                   start_i,
   input  logic                   rw_type_i,
   output logic                   busy_o,
   input  logic                   bank_we_i,
   input  logic                   pa_we_i,
   output logic                   search_en_o,
   output logic [SRCH_ADDR_W-1:0] search_addr_o,
   input  logic [SET_W-1:0]       set_i,
   input  logic                   res_valid_i,
   input  logic                   hit_i,
   input  logic                   prot_i,
   input  logic                   multi_i,
   input  logic                   coh_i,
   input  logic [PA_ADDR_W-1:0]   pa_idx_i,
   output logic                   pa_re_o,
   output logic [PA_ADDR_W-1:0]   pa_raddr_o,
   input  logic                   out_ready_i,
   output logic                   out_valid_o,
   output logic                   hit_o,
   output logic                   miss_o,
   output logic                   prot_o,
   output logic                   multi_o,
   output logic                   coh_o
);

   search_state_t        search_q, search_d;
   out_state_t           out_q, out_d;
   logic [OFFSET_W-1:0]  rd_off_q;          // Offset being read
   logic [OFFSET_W-1:0]  cmp_off_q;         // Offset being compared
   logic                 search_done;
   logic                 send_done;
   logic                 load_flags;
   logic                 clean_hit;
   logic                 found_hit_q, found_prot_q, found_multi_q, found_coh_q;
   logic [PA_ADDR_W-1:0] found_idx_q;

   assign busy_o        = (search_q != S_IDLE);
   assign search_en_o   = (search_q == S_SEARCH) && !bank_we_i;  // VA writes pause the walk
   assign search_addr_o = {set_i, rd_off_q};
   assign search_done   = (search_q == S_SEARCH) && res_valid_i &&
                          (hit_i || prot_i || multi_i || cmp_off_q == OFFSET_W'(N_OFFSETS - 1));
   assign out_valid_o   = (out_q == O_SEND);
   assign send_done     = out_valid_o && out_ready_i;
   assign clean_hit     = found_hit_q && !found_prot_q && !found_multi_q;
   assign pa_raddr_o    = found_idx_q;

   ////////////////////
   // Search FSM
   ////////////////////
   always_comb begin
      search_d = search_q;
      unique case (search_q)
         S_IDLE:   if (start_i) search_d = S_SEARCH;
         S_SEARCH: if (search_done) search_d = S_DONE;
         S_DONE:   if (send_done) search_d = S_IDLE;
         default:  search_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         search_q  <= S_IDLE;
         rd_off_q  <= '0;
         cmp_off_q <= '0;
      end else begin
         search_q <= search_d;
         if (search_q == S_IDLE) begin
            rd_off_q  <= '0;
            cmp_off_q <= '0;
         end else begin
            if (search_en_o) rd_off_q <= rd_off_q + 1'b1;
            if (res_valid_i) cmp_off_q <= cmp_off_q + 1'b1;
         end
      end
   end

   // Outcome of the walk kept until the result is sent
   always_ff @(posedge clk_i) begin
      if (search_done) begin
         found_hit_q   <= hit_i;
         found_prot_q  <= prot_i;
         found_multi_q <= multi_i;
         found_coh_q   <= coh_i;
         found_idx_q   <= pa_idx_i;
      end
   end

   ////////////////////
   // Result FSM
   ////////////////////
   always_comb begin
      out_d      = out_q;
      pa_re_o    = 1'b0;
      load_flags = 1'b0;
      unique case (out_q)
         O_IDLE: begin
            if (search_q == S_DONE) begin
               if (clean_hit && pa_we_i) begin
                  out_d = O_WAIT_WRITE;        // Table busy with a config write
               end else begin
                  out_d      = O_SEND;
                  load_flags = 1'b1;
                  pa_re_o    = clean_hit;      // Faults and misses need no PPN
               end
            end
         end
         O_WAIT_WRITE: begin
            if (!pa_we_i) begin
               out_d      = O_SEND;
               load_flags = 1'b1;
               pa_re_o    = 1'b1;
            end
         end
         O_SEND:  if (out_ready_i) out_d = O_IDLE;
         default: out_d = O_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         out_q   <= O_IDLE;
         hit_o   <= 1'b0;
         miss_o  <= 1'b0;
         prot_o  <= 1'b0;
         multi_o <= 1'b0;
         coh_o   <= 1'b0;
      end else begin
         out_q <= out_d;
         if (load_flags) begin
            hit_o   <= found_hit_q;
            miss_o  <= !found_hit_q;
            prot_o  <= found_prot_q;
            multi_o <= found_multi_q;
            coh_o   <= clean_hit && found_coh_q;  // Only with a translation
         end else if (send_done) begin
            hit_o   <= 1'b0;
            miss_o  <= 1'b0;
            prot_o  <= 1'b0;
            multi_o <= 1'b0;
            coh_o   <= 1'b0;
         end
      end
   end

   // Back-pressure holds the whole result
   a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && !out_ready_i |=>
         out_valid_o && $stable({hit_o, miss_o, prot_o, multi_o, coh_o}))
      else $error("lookup_ctrl: result changed under back-pressure");

   // Request fields must not move during a lookup
   a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      busy_o && !send_done |=> $stable({rw_type_i, set_i}))
      else $error("lookup_ctrl: request changed while busy");

endmodule

`default_nettype wire

// File: rtl/pa_table.sv
`timescale 1ns/1ps
`default_nettype none

module pa_table import l2tlb_pkg::*; (
   input  logic                 clk_i,
   input  logic                 rst_ni,
   input  logic                 we_i,
   input  logic [PA_ADDR_W-1:0] waddr_i,
   input  logic [PPN_W-1:0]     wdata_i,
   input  logic                 re_i,
   input  logic [PA_ADDR_W-1:0] raddr_i,
   output logic [PPN_W-1:0]     ppn_o
);

   logic [PPN_W-1:0]     mem [PA_DEPTH];
   logic [PA_ADDR_W-1:0] addr;
   logic [PPN_W-1:0]     ram_q;
   logic [PPN_W-1:0]     hold_q;
   logic                 rd_vld_q;

   // Single port where the write takes the address
   assign addr = we_i ? waddr_i : raddr_i;

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[addr] <= wdata_i;
      end else begin
         ram_q <= mem[addr];                  // Output unchanged on writes
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         rd_vld_q <= 1'b0;
         hold_q   <= '0;
      end else begin
         rd_vld_q <= re_i;
         if (rd_vld_q) begin
            hold_q <= ram_q;                  // Keep the looked-up PPN
         end
      end
   end

   assign ppn_o = rd_vld_q ? ram_q : hold_q;

   // Reads are only issued once no PA write is pending
   a_no_read_on_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(re_i && we_i))
      else $error("pa_table: read collides with a PA write");

endmodule

`default_nettype wire

// File: rtl/va_bank.sv
`timescale 1ns/1ps
`default_nettype none

module va_bank import l2tlb_pkg::*; (
   input  logic                   clk_i,
   input  logic                   we_i,
   input  logic [VA_ADDR_W-1:0]   waddr_i,
   input  logic [VA_DATA_W-1:0]   wdata_i,
   input  logic                   re_i,
   input  logic [SRCH_ADDR_W-1:0] raddr_i,
   input  logic [VPN_W-1:0]       vpn_i,
   input  logic                   rw_type_i,    // 1 for write access
   output logic                   valid_o,
   output logic [1:0]             hit_o,
   output logic [1:0]             prot_o,
   output logic [1:0]             coh_o
);

   logic [VA_DATA_W-1:0] mem [VA_DEPTH];
   logic [VA_DATA_W-1:0] rdata_q [2];
   logic [VA_ADDR_W-1:0] port_addr [2];
   logic                 valid_q;
   logic [1:0]           way_hit;
   logic [1:0]           way_perm;

   // Both ports look at the same set and offset with the port bit in the middle
   always_comb begin
      for (int p = 0; p < 2; p++) begin
         port_addr[p] = {raddr_i[SRCH_ADDR_W-1:OFFSET_W], 1'(p), raddr_i[OFFSET_W-1:0]};
      end
   end

   ////////////////////
   // Entry RAM
   ////////////////////
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;             // Writes win the shared port
      end else if (re_i) begin
         rdata_q[0] <= mem[port_addr[0]];
         rdata_q[1] <= mem[port_addr[1]];
      end
   end

   always_ff @(posedge clk_i) begin
      valid_q <= re_i && !we_i;
   end

   assign valid_o = valid_q;

   ////////////////////
   // Tag and permission compare
   ////////////////////
   always_comb begin
      for (int p = 0; p < 2; p++) begin
         way_hit[p]  = rdata_q[p][FLAG_VALID] && (rdata_q[p][VPN_W-1:0] == vpn_i);
         way_perm[p] = rw_type_i ? rdata_q[p][FLAG_WR] : rdata_q[p][FLAG_RD];
         hit_o[p]    = way_hit[p];
         prot_o[p]   = way_hit[p] && !way_perm[p];
         coh_o[p]    = rdata_q[p][FLAG_COH];
      end
   end

   // The controller must pause the search on every VA write
   a_no_read_on_write: assert property (@(posedge clk_i) !(re_i && we_i))
      else $error("va_bank: search read during a VA write");

endmodule

`default_nettype wire

// File: sim/tb_l2_tlb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l2_tlb import l2tlb_pkg::*; ();

   localparam int unsigned SEED    = 32'h4cda2b7b;
   localparam int          TIMEOUT = 200;       // Cycles allowed per wait

   logic                  clk_i = 1'b0;
   logic                  rst_ni;
   logic                  we_i;
   logic [CFG_ADDR_W-1:0] waddr_i;
   logic [CFG_DATA_W-1:0] wdata_i;
   logic                  start_i;
   logic                  busy_o;
   logic [S_ADDR_W-1:0]   in_addr_i;
   logic                  rw_type_i;
   logic                  out_ready_i;
   logic                  out_valid_o;
   logic                  hit_o, miss_o, prot_o, multi_o, coherent_o;
   logic [M_ADDR_W-1:0]   out_addr_o;

   // Reference copy of everything programmed into the DUT
   logic [VA_DATA_W-1:0]  va_mem [N_BANKS][VA_DEPTH];
   logic [PPN_W-1:0]      pa_mem [PA_DEPTH];

   // Expected result of the lookup in flight
   string                 test_name;
   logic                  exp_hit, exp_miss, exp_prot, exp_multi, exp_coh;
   logic                  exp_addr_chk;           // Address only on a clean hit
   logic [M_ADDR_W-1:0]   exp_addr;
   int unsigned           cur_set;

   int                    value_errors, hold_errors, timeouts, n_results;

   always #10 clk_i = ~clk_i;

   l2_tlb u_l2_tlb (.*);

   function automatic void report_mismatch(input string field,
         input logic [M_ADDR_W-1:0] expected, input logic [M_ADDR_W-1:0] actual);
      value_errors++;
      $display("Error: %s %s expected %0h actual %0h", test_name, field, expected, actual);
   endfunction

   ////////////////////
   // Result checks
   ////////////////////
   a_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && out_ready_i |-> hit_o == exp_hit)
      else report_mismatch("hit", M_ADDR_W'(exp_hit), M_ADDR_W'($sampled(hit_o)));

   a_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && out_ready_i |-> miss_o == exp_miss)
      else report_mismatch("miss", M_ADDR_W'(exp_miss), M_ADDR_W'($sampled(miss_o)));

   a_prot: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && out_ready_i |-> prot_o == exp_prot)
      else report_mismatch("prot", M_ADDR_W'(exp_prot), M_ADDR_W'($sampled(prot_o)));

   a_multi: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && out_ready_i |-> multi_o == exp_multi)
      else report_mismatch("multi", M_ADDR_W'(exp_multi), M_ADDR_W'($sampled(multi_o)));

   a_coh: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && out_ready_i |-> coherent_o == exp_coh)
      else report_mismatch("coherent", M_ADDR_W'(exp_coh), M_ADDR_W'($sampled(coherent_o)));

   a_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && out_ready_i && exp_addr_chk |-> out_addr_o == exp_addr)
      else report_mismatch("out_addr", exp_addr, $sampled(out_addr_o));

   // Back-pressure keeps the result and busy_o frozen
   a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && !out_ready_i |=> out_valid_o && busy_o &&
         $stable({hit_o, miss_o, prot_o, multi_o, coherent_o, out_addr_o}))
      else begin
         hold_errors++;
         $display("%s: result or busy_o changed while out_ready_i was low", test_name);
      end

   ////////////////////
   // Configuration writes
   ////////////////////
   task automatic put_va(input int bank, input logic [VA_ADDR_W-1:0] entry,
                         input logic [VA_DATA_W-1:0] data);
      we_i    <= 1'b1;
      waddr_i <= CFG_ADDR_W'({1'b0, entry, BANK_W'(bank)});
      wdata_i <= CFG_DATA_W'(data);
      va_mem[bank][entry] = data;
   endtask

   task automatic put_pa(input logic [PA_ADDR_W-1:0] idx, input logic [PPN_W-1:0] ppn);
      we_i    <= 1'b1;
      waddr_i <= CFG_ADDR_W'({1'b1, idx});     // Top bit selects the PA table
      wdata_i <= CFG_DATA_W'(ppn);
      pa_mem[idx] = ppn;
   endtask

   function automatic logic [VA_DATA_W-1:0] make_entry(input logic [VPN_W-1:0] vpn,
         input logic rd, input logic wr, input logic coh);
      return {coh, wr, rd, 1'b1, vpn};
   endfunction

   task automatic clear_tables();
      for (int b = 0; b < N_BANKS; b++) begin
         for (int e = 0; e < VA_DEPTH; e++) begin
            @(posedge clk_i);
            put_va(b, VA_ADDR_W'(e), '0);
         end
      end
      for (int i = 0; i < PA_DEPTH; i++) begin
         @(posedge clk_i);
         put_pa(PA_ADDR_W'(i), {8'ha5, PA_ADDR_W'(i), PA_ADDR_W'(i)});
      end
      @(posedge clk_i);
      we_i <= 1'b0;
   endtask

   // Unrelated write outside the set being searched
   task automatic noise_write();
      logic [SET_W-1:0]     wr_set;
      logic [VA_ADDR_W-1:0] entry;
      int                   bank;
      wr_set = SET_W'((cur_set + 1 + $urandom_range(N_SETS - 2)) % N_SETS);
      entry  = {wr_set, 1'($urandom_range(1)), OFFSET_W'($urandom_range(N_OFFSETS - 1))};
      bank   = $urandom_range(N_BANKS - 1);
      if ($urandom_range(1) == 0) begin
         put_va(bank, entry, VA_DATA_W'($urandom()));
      end else begin
         put_pa({entry, BANK_W'(bank)}, PPN_W'($urandom()));
      end
   endtask

   ////////////////////
   // Reference model
   ////////////////////
   task automatic predict(input logic [S_ADDR_W-1:0] addr, input logic rw);
      logic [VPN_W-1:0]     vpn;
      logic [VA_ADDR_W-1:0] entry;
      logic [VA_DATA_W-1:0] e;
      logic [PA_ADDR_W-1:0] win_idx;
      logic                 win_coh;
      int                   hits;
      vpn       = addr[S_ADDR_W-1:PAGE_W];
      exp_hit   = 1'b0;
      exp_prot  = 1'b0;
      exp_multi = 1'b0;
      win_idx   = '0;
      win_coh   = 1'b0;
      // First offset step with any hit ends the walk
      for (int off = 0; off < N_OFFSETS && !exp_hit; off++) begin
         hits = 0;
         for (int b = 0; b < N_BANKS; b++) begin
            for (int p = 0; p < 2; p++) begin
               entry = {vpn[SET_W-1:0], 1'(p), OFFSET_W'(off)};
               e     = va_mem[b][entry];
               if (e[FLAG_VALID] && e[VPN_W-1:0] == vpn) begin
                  if (hits == 0) begin
                     win_idx = {entry, BANK_W'(b)};   // Lowest bank and port 0 first
                     win_coh = e[FLAG_COH];
                  end
                  hits++;
                  if (!(rw ? e[FLAG_WR] : e[FLAG_RD])) exp_prot = 1'b1;
               end
            end
         end
         exp_hit   = hits > 0;
         exp_multi = hits > 1;
      end
      exp_miss     = !exp_hit;
      exp_addr_chk = exp_hit && !exp_prot && !exp_multi;
      exp_coh      = exp_addr_chk && win_coh;
      exp_addr     = {pa_mem[win_idx], addr[PAGE_W-1:0]};
   endtask

   ////////////////////
   // Lookup handshake
   ////////////////////
   task automatic wait_valid();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk_i);
         cycles++;
         start_i <= 1'b0;
      end while (!out_valid_o && cycles < TIMEOUT);
      if (!out_valid_o) begin
         timeouts++;
         $display("%s: out_valid_o never rose", test_name);
      end
   endtask

   task automatic wait_result(input bit noise);
      int cycles;
      bit done;
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < TIMEOUT) begin
         @(posedge clk_i);
         cycles++;
         start_i <= 1'b0;
         done = out_valid_o && out_ready_i;
         if (noise && !done && $urandom_range(2) == 0) begin
            noise_write();
         end else begin
            we_i <= 1'b0;
         end
      end
      if (done) begin
         n_results++;
      end else begin
         we_i <= 1'b0;
         timeouts++;
         $display("%s: no accepted result within %0d cycles", test_name, TIMEOUT);
      end
   endtask

   task automatic run_lookup(input string name, input logic [S_ADDR_W-1:0] addr,
                             input logic rw, input bit noise, input int bp);
      int cycles;
      if (timeouts != 0) return;
      cycles = 0;
      while (busy_o && cycles < TIMEOUT) begin
         @(posedge clk_i);
         cycles++;
      end
      if (busy_o) begin
         timeouts++;
         $display("%s: busy_o never dropped before the lookup", name);
         return;
      end
      test_name = name;
      cur_set   = 32'(addr[PAGE_W +: SET_W]);
      predict(addr, rw);
      in_addr_i   <= addr;
      rw_type_i   <= rw;
      start_i     <= 1'b1;
      out_ready_i <= (bp == 0);
      if (bp > 0) begin
         wait_valid();
         if (timeouts != 0) return;
         repeat (bp - 1) @(posedge clk_i);
         out_ready_i <= 1'b1;
      end
      wait_result(noise);
   endtask

   ////////////////////
   // Scenarios
   ////////////////////
   task automatic test_hit(input string name, input bit noise, input int bp);
      logic [VPN_W-1:0]     vpn;
      logic [VA_ADDR_W-1:0] entry;
      int                   bank;
      vpn   = VPN_W'($urandom());
      bank  = $urandom_range(N_BANKS - 1);
      entry = {vpn[SET_W-1:0], 1'($urandom_range(1)), OFFSET_W'($urandom_range(N_OFFSETS - 1))};
      @(posedge clk_i);
      put_va(bank, entry, make_entry(vpn, 1'b1, 1'b1, 1'($urandom_range(1))));
      @(posedge clk_i);
      put_pa({entry, BANK_W'(bank)}, PPN_W'($urandom()));
      @(posedge clk_i);
      we_i <= 1'b0;
      run_lookup(name, {vpn, PAGE_W'($urandom())}, 1'($urandom_range(1)), noise, bp);
   endtask

   // Same set holds a valid entry with another tag
   task automatic test_miss(input bit noise);
      logic [VPN_W-1:0]     vpn;
      logic [VA_ADDR_W-1:0] entry;
      vpn   = VPN_W'($urandom());
      entry = {vpn[SET_W-1:0], 1'($urandom_range(1)), OFFSET_W'($urandom_range(N_OFFSETS - 1))};
      @(posedge clk_i);
      put_va($urandom_range(N_BANKS - 1), entry,
             make_entry(vpn ^ (VPN_W'(1) << SET_W), 1'b1, 1'b1, 1'b1));
      @(posedge clk_i);
      we_i <= 1'b0;
      run_lookup("miss", {vpn, PAGE_W'($urandom())}, 1'($urandom_range(1)), noise, 0);
   endtask

   task automatic test_prot();
      logic [VPN_W-1:0]     vpn;
      logic [VA_ADDR_W-1:0] entry;
      vpn   = VPN_W'($urandom());
      entry = {vpn[SET_W-1:0], 1'($urandom_range(1)), OFFSET_W'($urandom_range(N_OFFSETS - 1))};
      @(posedge clk_i);
      put_va($urandom_range(N_BANKS - 1), entry, make_entry(vpn, 1'b1, 1'b0, 1'b1));
      @(posedge clk_i);
      we_i <= 1'b0;
      run_lookup("prot", {vpn, PAGE_W'($urandom())}, 1'b1, 1'b0, 0);   // Write access
   endtask

   task automatic test_multi();
      logic [VPN_W-1:0]     vpn;
      logic [VA_ADDR_W-1:0] entry;
      int                   b0, b1;
      vpn   = VPN_W'($urandom());
      b0    = $urandom_range(N_BANKS - 1);
      b1    = (b0 + 1 + $urandom_range(N_BANKS - 2)) % N_BANKS;
      entry = {vpn[SET_W-1:0], 1'($urandom_range(1)), OFFSET_W'($urandom_range(N_OFFSETS - 1))};
      @(posedge clk_i);
      put_va(b0, entry, make_entry(vpn, 1'b1, 1'b1, 1'b1));
      @(posedge clk_i);
      put_va(b1, entry, make_entry(vpn, 1'b1, 1'b1, 1'b0));
      @(posedge clk_i);
      we_i <= 1'b0;
      run_lookup("multi", {vpn, PAGE_W'($urandom())}, 1'b0, 1'b0, 0);
   endtask

   initial begin
      void'($urandom(SEED));
      rst_ni       = 1'b0;
      we_i         = 1'b0;
      waddr_i      = '0;
      wdata_i      = '0;
      start_i      = 1'b0;
      in_addr_i    = '0;
      rw_type_i    = 1'b0;
      out_ready_i  = 1'b1;
      value_errors = 0;
      hold_errors  = 0;
      timeouts     = 0;
      n_results    = 0;
      exp_addr_chk = 1'b0;
      test_name    = "reset";

      repeat (10) @(posedge clk_i);
      rst_ni <= 1'b1;
      @(posedge clk_i);
      assert (!busy_o && !out_valid_o && !hit_o && !miss_o && !prot_o && !multi_o
              && !coherent_o)
      else begin
         value_errors++;
         $display("Error: reset outputs expected 0000000 actual %b",
                  {busy_o, out_valid_o, hit_o, miss_o, prot_o, multi_o, coherent_o});
      end

      clear_tables();
      for (int i = 0; i < 16; i++) test_hit("hit", 1'b0, 0);
      for (int i = 0; i < 16; i++) test_hit("hit_busy_writes", 1'b1, 0);
      for (int i = 0; i < 10; i++) test_miss(i[0]);
      for (int i = 0; i < 10; i++) test_prot();
      for (int i = 0; i < 10; i++) test_multi();
      for (int i = 0; i < 12; i++) test_hit("backpressure", 1'b0, $urandom_range(8, 1));

      $display("Results %0d, value errors %0d, hold errors %0d, timeouts %0d",
               n_results, value_errors, hold_errors, timeouts);
      if (value_errors == 0 && hold_errors == 0 && timeouts == 0 && n_results > 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
